/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_issue
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench printed the pass message
run: build
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* design/fu_agu.sv */
`timescale 1ns/1ns
`default_nettype none

module fu_agu
    import mem_rs_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,

    input  wire logic       issue_valid,
    input  wire rob_id_t    rob_id,
    input  wire mem_op_e    opcode,
    input  wire word_t      imm,
    input  wire word_t      rs1_value,
    input  wire word_t      rs2_value,

    // To the load/store queue
    output logic            agu_valid,
    output rob_id_t         agu_rob_id,
    output mem_op_e         agu_opcode,
    output word_t           agu_addr,
    output word_t           agu_store_data,
    output logic            agu_misaligned
);

    word_t  eff_addr;
    logic   misaligned;

    assign eff_addr = rs1_value + imm;

    // Alignment by access size
    always_comb begin
        case (opcode)
            op_lh, op_lhu, op_sh: misaligned = eff_addr[0];
            op_lw, op_sw:         misaligned = |eff_addr[1:0];
            default:              misaligned = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Output stage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            agu_valid <= 1'b0;
        end else begin
            agu_valid <= issue_valid;
        end
    end

    // Payload only moves with an issue
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            agu_rob_id     <= rob_id;
            agu_opcode     <= opcode;
            agu_addr       <= eff_addr;
            agu_store_data <= rs2_value;
            agu_misaligned <= misaligned;
        end
    end

endmodule

`default_nettype wire

/* design/mem_issue_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_rs_cfg.svh"

module mem_issue_top
    import mem_rs_pkg::*;
(
    input  wire logic                         clk,
    input  wire logic                         rst_n,

    input  wire logic                         dispatch_valid,
    output logic                              dispatch_ready,
    input  wire rob_id_t                      dispatch_rob_id,
    input  wire mem_op_e                      dispatch_opcode,
    input  wire phys_reg_t                    dispatch_rs1_phy,
    input  wire logic                         dispatch_rs1_ready,
    input  wire phys_reg_t                    dispatch_rs2_phy,
    input  wire logic                         dispatch_rs2_ready,
    input  wire word_t                        dispatch_imm,

    input  wire logic      [`CDB_WIDTH-1:0]   cdb_valid,
    input  wire phys_reg_t [`CDB_WIDTH-1:0]   cdb_tag,
    input  wire word_t     [`CDB_WIDTH-1:0]   cdb_value,

    output logic                              agu_valid,
    output rob_id_t                           agu_rob_id,
    output mem_op_e                           agu_opcode,
    output word_t                             agu_addr,
    output word_t                             agu_store_data,
    output logic                              agu_misaligned
);

    // Station to register file
    phys_reg_t  rs1_phy;
    phys_reg_t  rs2_phy;
    word_t      rs1_value;
    word_t      rs2_value;

    mem_rs u_mem_rs (
        .clk                (clk),
        .rst_n              (rst_n),
        .dispatch_valid     (dispatch_valid),
        .dispatch_ready     (dispatch_ready),
        .dispatch_rob_id    (dispatch_rob_id),
        .dispatch_opcode    (dispatch_opcode),
        .dispatch_rs1_phy   (dispatch_rs1_phy),
        .dispatch_rs1_ready (dispatch_rs1_ready),
        .dispatch_rs2_phy   (dispatch_rs2_phy),
        .dispatch_rs2_ready (dispatch_rs2_ready),
        .dispatch_imm       (dispatch_imm),
        .cdb_valid          (cdb_valid),
        .cdb_tag            (cdb_tag),
        .rs1_phy            (rs1_phy),
        .rs2_phy            (rs2_phy),
        .rs1_value          (rs1_value),
        .rs2_value          (rs2_value),
        .agu_valid          (agu_valid),
        .agu_rob_id         (agu_rob_id),
        .agu_opcode         (agu_opcode),
        .agu_addr           (agu_addr),
        .agu_store_data     (agu_store_data),
        .agu_misaligned     (agu_misaligned)
    );

    prf u_prf (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value)
    );

endmodule

`default_nettype wire

/* design/mem_rs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_rs_cfg.svh"

module mem_rs
    import mem_rs_pkg::*;
(
    input  wire logic                         clk,
    input  wire logic                         rst_n,

    // Dispatch
    input  wire logic                         dispatch_valid,
    output logic                              dispatch_ready,
    input  wire rob_id_t                      dispatch_rob_id,
    input  wire mem_op_e                      dispatch_opcode,
    input  wire phys_reg_t                    dispatch_rs1_phy,
    input  wire logic                         dispatch_rs1_ready,
    input  wire phys_reg_t                    dispatch_rs2_phy,
    input  wire logic                         dispatch_rs2_ready,
    input  wire word_t                        dispatch_imm,

    input  wire logic      [`CDB_WIDTH-1:0]   cdb_valid,
    input  wire phys_reg_t [`CDB_WIDTH-1:0]   cdb_tag,

    // Register read
    output phys_reg_t                         rs1_phy,
    output phys_reg_t                         rs2_phy,
    input  wire word_t                        rs1_value,
    input  wire word_t                        rs2_value,

    output logic                              agu_valid,
    output rob_id_t                           agu_rob_id,
    output mem_op_e                           agu_opcode,
    output word_t                             agu_addr,
    output word_t                             agu_store_data,
    output logic                              agu_misaligned
);

    //////////////////////////////////////////////////////////////////////
    // Slots
    //////////////////////////////////////////////////////////////////////

    logic          [`MEMRS_DEPTH-1:0]   slot_valid;
    logic          [`MEMRS_DEPTH-1:0]   slot_request;
    logic          [`MEMRS_DEPTH-1:0]   slot_grant;
    logic          [`MEMRS_DEPTH-1:0]   push_en;
    mem_rs_entry_t [`MEMRS_DEPTH-1:0]   slot_entry;
    mem_rs_entry_t                      dispatch_entry;
    mem_rs_entry_t                      issued_entry;

    always_comb begin
        dispatch_entry.rob_id    = dispatch_rob_id;
        dispatch_entry.rs1_phy   = dispatch_rs1_phy;
        dispatch_entry.rs1_ready = dispatch_rs1_ready;
        dispatch_entry.rs2_phy   = dispatch_rs2_phy;
        dispatch_entry.rs2_ready = dispatch_rs2_ready;
        dispatch_entry.imm       = dispatch_imm;
        dispatch_entry.opcode    = dispatch_opcode;
    end

    for (genvar i = 0; i < `MEMRS_DEPTH; i++) begin : g_slot
        rs_entry u_rs_entry (
            .clk       (clk),
            .rst_n     (rst_n),
            .push_en   (push_en[i]),
            .entry_in  (dispatch_entry),
            .grant     (slot_grant[i]),
            .cdb_valid (cdb_valid),
            .cdb_tag   (cdb_tag),
            .valid     (slot_valid[i]),
            .request   (slot_request[i]),
            .entry     (slot_entry[i])
        );
    end

    assign dispatch_ready = |(~slot_valid);

    // First free slot takes the transfer
    always_comb begin
        push_en = '0;
        if (dispatch_valid && dispatch_ready) begin
            for (int i = 0; i < `MEMRS_DEPTH; i++) begin
                if (!slot_valid[i] && (push_en == '0)) begin
                    push_en[i] = 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Issue select
    //////////////////////////////////////////////////////////////////////

    // Lowest index wins
    always_comb begin
        slot_grant = '0;
        for (int i = 0; i < `MEMRS_DEPTH; i++) begin
            if (slot_request[i] && (slot_grant == '0)) begin
                slot_grant[i] = 1'b1;
            end
        end
    end

    // AND-OR mux on the one-hot grant
    always_comb begin
        issued_entry = '0;
        for (int i = 0; i < `MEMRS_DEPTH; i++) begin
            if (slot_grant[i]) begin
                issued_entry = mem_rs_entry_t'(issued_entry | slot_entry[i]);
            end
        end
    end

    assign rs1_phy = issued_entry.rs1_phy;
    assign rs2_phy = issued_entry.rs2_phy;

    fu_agu u_fu_agu (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (|slot_grant),
        .rob_id         (issued_entry.rob_id),
        .opcode         (issued_entry.opcode),
        .imm            (issued_entry.imm),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .agu_valid      (agu_valid),
        .agu_rob_id     (agu_rob_id),
        .agu_opcode     (agu_opcode),
        .agu_addr       (agu_addr),
        .agu_store_data (agu_store_data),
        .agu_misaligned (agu_misaligned)
    );

    grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(slot_grant)
    ) else $error("mem_rs: more than one slot granted");

    push_needs_free_slot: assert property (
        @(posedge clk) disable iff (!rst_n)
        (push_en & slot_valid) == '0
    ) else $error("mem_rs: push into an occupied slot");

endmodule

`default_nettype wire

/* design/mem_rs_cfg.svh */
`ifndef MEM_RS_CFG_SVH
`define MEM_RS_CFG_SVH

// Reservation station slots
`define MEMRS_DEPTH 4

// Physical register file
`define PRF_DEPTH 32

// Broadcast lanes per cycle
`define CDB_WIDTH 2

`define XLEN 32
`define ROB_BITS 4

`endif

/* design/mem_rs_pkg.sv */
`default_nettype none

`include "mem_rs_cfg.svh"

package mem_rs_pkg;

    //////////////////////////////////////////////////////////////////////
    // Basic types
    //////////////////////////////////////////////////////////////////////

    typedef logic [`XLEN-1:0]               word_t;
    typedef logic [$clog2(`PRF_DEPTH)-1:0]  phys_reg_t;
    typedef logic [`ROB_BITS-1:0]           rob_id_t;

    // Memory micro-op encodings
    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lh  = 3'd1,
        op_lw  = 3'd2,
        op_lbu = 3'd3,
        op_lhu = 3'd4,
        op_sb  = 3'd5,
        op_sh  = 3'd6,
        op_sw  = 3'd7
    } mem_op_e;

    //////////////////////////////////////////////////////////////////////
    // Station slot contents
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        rob_id_t    rob_id;
        phys_reg_t  rs1_phy;
        logic       rs1_ready;
        // Loads arrive with rs2 already ready
        phys_reg_t  rs2_phy;
        logic       rs2_ready;
        word_t      imm;
        mem_op_e    opcode;
    } mem_rs_entry_t;

endpackage

`default_nettype wire

/* design/prf.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_rs_cfg.svh"

module prf
    import mem_rs_pkg::*;
(
    input  wire logic                         clk,
    input  wire logic                         rst_n,

    // Read ports from the station
    input  wire phys_reg_t                    rs1_phy,
    input  wire phys_reg_t                    rs2_phy,
    output word_t                             rs1_value,
    output word_t                             rs2_value,

    // Result broadcast
    input  wire logic      [`CDB_WIDTH-1:0]   cdb_valid,
    input  wire phys_reg_t [`CDB_WIDTH-1:0]   cdb_tag,
    input  wire word_t     [`CDB_WIDTH-1:0]   cdb_value
);

    word_t  regs [`PRF_DEPTH];
    logic   lane_dup;

    //////////////////////////////////////////////////////////////////////
    // Write side with one port per CDB lane
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `PRF_DEPTH; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < `CDB_WIDTH; l++) begin
                if (cdb_valid[l]) begin
                    regs[cdb_tag[l]] <= cdb_value[l];
                end
            end
        end
    end

    // Reads see the value before this edge's writes
    assign rs1_value = regs[rs1_phy];
    assign rs2_value = regs[rs2_phy];

    // Same tag on two live lanes means a rename bug upstream
    always_comb begin
        lane_dup = 1'b0;
        for (int a = 0; a < `CDB_WIDTH; a++) begin
            for (int b = a + 1; b < `CDB_WIDTH; b++) begin
                if (cdb_valid[a] && cdb_valid[b] && (cdb_tag[a] == cdb_tag[b])) begin
                    lane_dup = 1'b1;
                end
            end
        end
    end

    cdb_tags_unique: assert property (
        @(posedge clk) disable iff (!rst_n)
        !lane_dup
    ) else $error("prf: two CDB lanes write the same tag");

endmodule

`default_nettype wire

/* design/rs_entry.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_rs_cfg.svh"

module rs_entry
    import mem_rs_pkg::*;
(
    input  wire logic                         clk,
    input  wire logic                         rst_n,

    input  wire logic                         push_en,
    input  wire mem_rs_entry_t                entry_in,
    input  wire logic                         grant,

    input  wire logic      [`CDB_WIDTH-1:0]   cdb_valid,
    input  wire phys_reg_t [`CDB_WIDTH-1:0]   cdb_tag,

    output logic                              valid,
    output logic                              request,
    output mem_rs_entry_t                     entry
);

    mem_rs_entry_t  src_entry;
    mem_rs_entry_t  entry_next;
    logic           rs1_hit;
    logic           rs2_hit;

    // On a push the incoming tags are snooped, otherwise the held ones
    always_comb begin
        src_entry = push_en ? entry_in : entry;
        rs1_hit   = 1'b0;
        rs2_hit   = 1'b0;
        for (int l = 0; l < `CDB_WIDTH; l++) begin
            if (cdb_valid[l] && (cdb_tag[l] == src_entry.rs1_phy)) begin
                rs1_hit = 1'b1;
            end
            if (cdb_valid[l] && (cdb_tag[l] == src_entry.rs2_phy)) begin
                rs2_hit = 1'b1;
            end
        end
    end

    always_comb begin
        entry_next           = src_entry;
        entry_next.rs1_ready = src_entry.rs1_ready | rs1_hit;
        entry_next.rs2_ready = src_entry.rs2_ready | rs2_hit;
    end

    // Slot occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (push_en) begin
            valid <= 1'b1;
        end else if (grant) begin
            valid <= 1'b0;
        end
    end

    // Micro-op payload and wakeup bits
    always_ff @(posedge clk) begin
        if (push_en || valid) begin
            entry <= entry_next;
        end
    end

    assign request = valid & entry.rs1_ready & entry.rs2_ready;

    // The station picks only among requesting slots
    grant_needs_request: assert property (
        @(posedge clk) disable iff (!rst_n)
        grant |-> request
    ) else $error("rs_entry: grant without request");

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/mem_rs_pkg.sv
design/rs_entry.sv
design/prf.sv
design/fu_agu.sv
design/mem_rs.sv
design/mem_issue_top.sv
tb/tb_clk_gen.sv
tb/tb_mem_issue.sv

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int CLK_PERIOD   = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Release on a falling edge away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/tb_mem_issue.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_rs_cfg.svh"

module tb_mem_issue
    import mem_rs_pkg::*;
();

    localparam int RESET_CYCLES    = 4;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 40;
    localparam int CYCLE_LIMIT     = NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES;
    localparam int SWEEP_CASES     = 32;

    // Register tags used by the tests
    localparam phys_reg_t ZERO_REG       = 0;
    localparam phys_reg_t ADDR_REG       = 5;
    localparam phys_reg_t STORE_DATA_REG = 6;
    localparam phys_reg_t LOAD_REG       = 9;
    localparam phys_reg_t BYPASS_REG     = 12;
    localparam phys_reg_t SHARED_REG     = 20;
    localparam phys_reg_t ALIGN_REG      = 25;

    logic                         clk;
    logic                         rst_n;
    logic                         dispatch_valid;
    logic                         dispatch_ready;
    rob_id_t                      dispatch_rob_id;
    mem_op_e                      dispatch_opcode;
    phys_reg_t                    dispatch_rs1_phy;
    logic                         dispatch_rs1_ready;
    phys_reg_t                    dispatch_rs2_phy;
    logic                         dispatch_rs2_ready;
    word_t                        dispatch_imm;
    logic      [`CDB_WIDTH-1:0]   cdb_valid;
    phys_reg_t [`CDB_WIDTH-1:0]   cdb_tag;
    word_t     [`CDB_WIDTH-1:0]   cdb_value;
    logic                         agu_valid;
    rob_id_t                      agu_rob_id;
    mem_op_e                      agu_opcode;
    word_t                        agu_addr;
    word_t                        agu_store_data;
    logic                         agu_misaligned;

    // Mirror of every CDB write
    word_t  ref_regs [`PRF_DEPTH];
    int     seed        = 32'h41132fbb;
    int     cycle_count = 0;

    tb_clk_gen #(.CLK_PERIOD(40), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_issue_top u_dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .dispatch_valid     (dispatch_valid),
        .dispatch_ready     (dispatch_ready),
        .dispatch_rob_id    (dispatch_rob_id),
        .dispatch_opcode    (dispatch_opcode),
        .dispatch_rs1_phy   (dispatch_rs1_phy),
        .dispatch_rs1_ready (dispatch_rs1_ready),
        .dispatch_rs2_phy   (dispatch_rs2_phy),
        .dispatch_rs2_ready (dispatch_rs2_ready),
        .dispatch_imm       (dispatch_imm),
        .cdb_valid          (cdb_valid),
        .cdb_tag            (cdb_tag),
        .cdb_value          (cdb_value),
        .agu_valid          (agu_valid),
        .agu_rob_id         (agu_rob_id),
        .agu_opcode         (agu_opcode),
        .agu_addr           (agu_addr),
        .agu_store_data     (agu_store_data),
        .agu_misaligned     (agu_misaligned)
    );

    //////////////////////////////////////////////////////////////////////
    // Failure handling and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_op(input string name, input mem_op_e got, input mem_op_e exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h (%s), expected 0x%h (%s)",
                     name, got, got.name(), exp, exp.name());
            abort_run();
        end
    endtask

    task automatic check_rob(input string name, input rob_id_t got, input rob_id_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic int access_bytes(input mem_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            default:              return 4;
        endcase
    endfunction

    // Natural alignment to the access size
    function automatic logic misaligned_by_rule(input mem_op_e op, input word_t addr);
        return (addr % access_bytes(op)) != 0;
    endfunction

    function automatic logic is_store(input mem_op_e op);
        return (op == op_sb) || (op == op_sh) || (op == op_sw);
    endfunction

    // Move to the next falling edge and drop the strobes
    task automatic step();
        @(negedge clk);
        dispatch_valid = 1'b0;
        cdb_valid      = '0;
    endtask

    task automatic drive_cdb(input int lane, input phys_reg_t tag, input word_t value);
        cdb_valid[lane] = 1'b1;
        cdb_tag[lane]   = tag;
        cdb_value[lane] = value;
        ref_regs[tag]   = value;
    endtask

    task automatic drive_dispatch(input rob_id_t rob, input mem_op_e op,
                                  input phys_reg_t rs1, input logic rs1_rdy,
                                  input phys_reg_t rs2, input logic rs2_rdy,
                                  input word_t imm);
        while (!dispatch_ready) @(negedge clk);
        dispatch_valid     = 1'b1;
        dispatch_rob_id    = rob;
        dispatch_opcode    = op;
        dispatch_rs1_phy   = rs1;
        dispatch_rs1_ready = rs1_rdy;
        dispatch_rs2_phy   = rs2;
        dispatch_rs2_ready = rs2_rdy;
        dispatch_imm       = imm;
    endtask

    task automatic expect_issue(input rob_id_t rob, input mem_op_e op, input phys_reg_t rs1,
                                input phys_reg_t rs2, input word_t imm);
        word_t exp_addr;
        exp_addr = ref_regs[rs1] + imm;
        check_bit("agu_valid", agu_valid, 1'b1);
        check_rob("agu_rob_id", agu_rob_id, rob);
        check_op("agu_opcode", agu_opcode, op);
        check_word("agu_addr", agu_addr, exp_addr);
        check_word("agu_store_data", agu_store_data, ref_regs[rs2]);
        check_bit("agu_misaligned", agu_misaligned, misaligned_by_rule(op, exp_addr));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic after_reset();
        check_bit("agu_valid", agu_valid, 1'b0);
        check_bit("dispatch_ready", dispatch_ready, 1'b1);
    endtask

    task automatic ready_store();
        word_t imm;
        imm = rand_word();
        drive_cdb(0, ADDR_REG, rand_word());
        drive_cdb(1, STORE_DATA_REG, rand_word());
        step();
        drive_dispatch(rob_id_t'(3), op_sw, ADDR_REG, 1'b1, STORE_DATA_REG, 1'b1, imm);
        step();
        check_bit("agu_valid", agu_valid, 1'b0);
        step();
        expect_issue(rob_id_t'(3), op_sw, ADDR_REG, STORE_DATA_REG, imm);
        step();
        check_bit("agu_valid", agu_valid, 1'b0);
    endtask

    task automatic wakeup_load();
        word_t imm;
        imm = rand_word();
        drive_dispatch(rob_id_t'(4), op_lw, LOAD_REG, 1'b0, ZERO_REG, 1'b1, imm);
        repeat (6) begin
            step();
            check_bit("agu_valid", agu_valid, 1'b0);
        end
        drive_cdb(1, LOAD_REG, rand_word());
        step();
        check_bit("agu_valid", agu_valid, 1'b0);
        step();
        expect_issue(rob_id_t'(4), op_lw, LOAD_REG, ZERO_REG, imm);

        // Tag broadcast on the dispatch edge itself
        imm = rand_word();
        drive_dispatch(rob_id_t'(5), op_lh, BYPASS_REG, 1'b0, ZERO_REG, 1'b1, imm);
        drive_cdb(0, BYPASS_REG, rand_word());
        step();
        check_bit("agu_valid", agu_valid, 1'b0);
        step();
        expect_issue(rob_id_t'(5), op_lh, BYPASS_REG, ZERO_REG, imm);
        step();
        check_bit("agu_valid", agu_valid, 1'b0);
    endtask

    task automatic fill_and_drain();
        mem_op_e    fill_op  [`MEMRS_DEPTH];
        word_t      fill_imm [`MEMRS_DEPTH];
        phys_reg_t  fill_rs2 [`MEMRS_DEPTH];
        for (int i = 0; i < `MEMRS_DEPTH; i++) begin
            fill_op[i]  = mem_op_e'((3 * i + 5) % 8);
            fill_imm[i] = rand_word();
            fill_rs2[i] = is_store(fill_op[i]) ? STORE_DATA_REG : ZERO_REG;
        end
        check_bit("dispatch_ready", dispatch_ready, 1'b1);
        for (int i = 0; i < `MEMRS_DEPTH; i++) begin
            drive_dispatch(rob_id_t'(8 + i), fill_op[i], SHARED_REG, 1'b0,
                           fill_rs2[i], 1'b1, fill_imm[i]);
            step();
        end
        check_bit("dispatch_ready", dispatch_ready, 1'b0);
        check_bit("agu_valid", agu_valid, 1'b0);
        // One wakeup releases every slot
        drive_cdb(0, SHARED_REG, rand_word());
        step();
        check_bit("agu_valid", agu_valid, 1'b0);
        for (int i = 0; i < `MEMRS_DEPTH; i++) begin
            step();
            expect_issue(rob_id_t'(8 + i), fill_op[i], SHARED_REG, fill_rs2[i], fill_imm[i]);
        end
        step();
        check_bit("agu_valid", agu_valid, 1'b0);
        check_bit("dispatch_ready", dispatch_ready, 1'b1);
    endtask

    task automatic alignment_sweep();
        mem_op_e    sweep_op  [SWEEP_CASES];
        word_t      sweep_imm [SWEEP_CASES];
        phys_reg_t  sweep_rs2 [SWEEP_CASES];
        logic [1:0] low_bits;
        word_t      base;
        drive_cdb(0, ALIGN_REG, rand_word());
        step();
        base = ref_regs[ALIGN_REG];
        // Every opcode against every value of address bits 1:0
        for (int c = 0; c < SWEEP_CASES; c++) begin
            low_bits           = c[1:0];
            sweep_op[c]        = mem_op_e'(c[4:2]);
            sweep_imm[c]       = rand_word();
            sweep_imm[c][1:0]  = low_bits - base[1:0];
            sweep_rs2[c]       = is_store(sweep_op[c]) ? STORE_DATA_REG : ZERO_REG;
        end
        for (int c = 0; c < SWEEP_CASES + 2; c++) begin
            if (c >= 2) begin
                expect_issue(rob_id_t'(c - 2), sweep_op[c - 2], ALIGN_REG,
                             sweep_rs2[c - 2], sweep_imm[c - 2]);
            end
            if (c < SWEEP_CASES) begin
                drive_dispatch(rob_id_t'(c), sweep_op[c], ALIGN_REG, 1'b1,
                               sweep_rs2[c], 1'b1, sweep_imm[c]);
            end
            step();
        end
        check_bit("agu_valid", agu_valid, 1'b0);
    endtask

    initial begin
        dispatch_valid     = 1'b0;
        dispatch_rob_id    = '0;
        dispatch_opcode    = op_lb;
        dispatch_rs1_phy   = '0;
        dispatch_rs1_ready = 1'b0;
        dispatch_rs2_phy   = '0;
        dispatch_rs2_ready = 1'b0;
        dispatch_imm       = '0;
        cdb_valid          = '0;
        cdb_tag            = '0;
        cdb_value          = '0;
        for (int r = 0; r < `PRF_DEPTH; r++) begin
            ref_regs[r] = '0;
        end
        @(posedge rst_n);
        @(negedge clk);
        after_reset();
        ready_store();
        wakeup_load();
        fill_and_drain();
        alignment_sweep();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
